// File: bench/raycastTb.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module raycastTb;

  localparam int mapWords = `RC_MAP_DIM * `RC_MAP_DIM;
  localparam int rayWords = 17; // job fields plus expected result per ray
  localparam int maxRays = 32;

  logic pixel_clk_in;
  logic rst_in;
  logic rayValid;
  rayPkg::rayJobT rayIn;
  logic rayBusy;
  logic mapWe;
  rayPkg::mapAddrT mapWrAddr;
  rayPkg::tileT mapWrData;
  logic colValid;
  rayPkg::colResultT colOut;

  logic [15:0] stim [0:1 + mapWords + maxRays * rayWords]; // count, map, rays
  int numRays;
  int valErrs;
  int protoErrs;
  int assertErrs;
  int seenCnt [maxRays]; // results per column
  int gotTotal;
  bit raysStarted;
  bit allBusy; // every core was walking at once
  bit loaded;
  logic [31:0] lfsr;

  raycastTop raycastTop_i (
    .pixel_clk_in(pixel_clk_in),
    .rst_in(rst_in),
    .rayValid(rayValid),
    .rayIn(rayIn),
    .rayBusy(rayBusy),
    .mapWe(mapWe),
    .mapWrAddr(mapWrAddr),
    .mapWrData(mapWrData),
    .colValid(colValid),
    .colOut(colOut)
  );

  always #10 pixel_clk_in = ~pixel_clk_in;

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic drawGap(output int gap);
    gap = 0;
    for (int b = 0; b < 3; b++) begin
      lfsr = lfsrNext(lfsr); // one step per bit
      gap = gap * 2 + int'(lfsr[0]);
    end
  endtask

  function automatic logic [15:0] rayWord(input int r, input int k);
    return stim[1 + mapWords + r * rayWords + k];
  endfunction

  task automatic checkField(input string name, input logic [15:0] exp, input logic [15:0] got);
    assert (exp == got) else begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      valErrs++;
    end
  endtask

  // outputs are registered at the rising edge, so look at them on the falling one
  always @(negedge pixel_clk_in) begin : watchOut
    int col;
    if (!rst_in && !raysStarted) begin
      assert (!colValid && !rayBusy) else begin
        $display("colValid or rayBusy high before the first ray");
        protoErrs++;
      end
    end
    if (raysStarted && raycastTop_i.coreIdle == '0) begin
      allBusy = 1'b1;
      assert (rayBusy) else begin
        $display("rayBusy low while every core is walking");
        protoErrs++;
      end
    end
    if (!rst_in && colValid) begin
      col = int'(colOut.column);
      gotTotal++;
      if (col >= numRays) begin
        $display("result for unknown column %0d", col);
        protoErrs++;
      end else begin
        seenCnt[col]++;
        if (seenCnt[col] > 1) begin
          $display("column %0d returned more than once", col);
          protoErrs++;
        end
        checkField("lineHeight", rayWord(col, 13), 16'(colOut.lineHeight));
        checkField("wallSide", rayWord(col, 14), 16'(colOut.wallSide));
        checkField("tile", rayWord(col, 15), 16'(colOut.tile));
        checkField("wallX", rayWord(col, 16), 16'(colOut.wallX));
      end
    end
  end

  initial begin : drive
    int gap;
    pixel_clk_in = 1'b0;
    rst_in = 1'b1;
    rayValid = 1'b0;
    rayIn = '0;
    mapWe = 1'b0;
    mapWrAddr = '0;
    mapWrData = '0;
    lfsr = 32'h114f7584;
    $readmemh("bench/raycast_stim.txt", stim);
    numRays = int'(stim[0]);
    loaded = 1'b1;
    repeat (16) @(negedge pixel_clk_in);
    rst_in = 1'b0;
    for (int i = 0; i < mapWords; i++) begin
      @(negedge pixel_clk_in);
      mapWe = 1'b1;
      mapWrAddr = rayPkg::mapAddrT'(i); // file order is x + y*dim
      mapWrData = stim[1 + i][3:0];
    end
    @(negedge pixel_clk_in);
    mapWe = 1'b0;
    repeat (20) @(negedge pixel_clk_in); // quiet window after load
    for (int r = 0; r < numRays; r++) begin
      while (rayBusy) @(negedge pixel_clk_in);
      raysStarted = 1'b1;
      rayValid = 1'b1;
      rayIn.column = rayPkg::columnT'(rayWord(r, 0));
      rayIn.stepXNeg = 1'(rayWord(r, 1));
      rayIn.stepYNeg = 1'(rayWord(r, 2));
      rayIn.rayDirX = rayWord(r, 3);
      rayIn.rayDirY = rayWord(r, 4);
      rayIn.deltaDistX = rayWord(r, 5);
      rayIn.deltaDistY = rayWord(r, 6);
      rayIn.posX = rayWord(r, 7);
      rayIn.posY = rayWord(r, 8);
      rayIn.sideDistX = rayWord(r, 9);
      rayIn.sideDistY = rayWord(r, 10);
      rayIn.mapX = rayPkg::mapCoordT'(rayWord(r, 11));
      rayIn.mapY = rayPkg::mapCoordT'(rayWord(r, 12));
      @(negedge pixel_clk_in);
      rayValid = 1'b0;
      drawGap(gap);
      repeat (gap) @(negedge pixel_clk_in);
    end
    while (gotTotal < numRays) @(negedge pixel_clk_in);
    repeat (20) @(negedge pixel_clk_in); // catch stray extra results
    for (int c = 0; c < numRays; c++) begin
      assert (seenCnt[c] != 0) else begin
        $display("column %0d never returned", c);
        protoErrs++;
      end
    end
    assert (allBusy) else begin
      $display("all cores were never busy together");
      protoErrs++;
    end
    assertErrs = raycastTop_i.raycast_chk_i.chkErrs;
    $display("value errors %0d, protocol errors %0d, assertion errors %0d",
             valErrs, protoErrs, assertErrs);
    if (valErrs == 0 && protoErrs == 0 && assertErrs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // run length follows the ray count from the stim file
  initial begin : watchdog
    wait (loaded);
    repeat (numRays * 400 + 2000 + mapWords) @(posedge pixel_clk_in);
    $display("timeout, not all column results arrived");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: bench/raycast_chk.sv
`timescale 1ns/1ps

module raycast_chk (
  input logic pixel_clk_in,
  input logic rst_in,
  input logic rayValid,
  input logic rayBusy,
  input logic colValid,
  input rayPkg::coreSelT mapValid
);

  int chkErrs = 0; // failed assertions, read by the testbench

  // result strobe is a single cycle pulse
  colPulse: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    colValid |=> !colValid)
    else begin
      $error("colValid high for two cycles");
      chkErrs++;
    end

  // at most one map answer per cycle
  mapOneHot: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    $onehot0(mapValid))
    else begin
      $error("mapValid not one-hot");
      chkErrs++;
    end

  rayProto: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    rayValid |-> !rayBusy)
    else begin
      $error("rayValid while rayBusy");
      chkErrs++;
    end

endmodule

bind raycastTop raycast_chk raycast_chk_i (
  .pixel_clk_in(pixel_clk_in),
  .rst_in(rst_in),
  .rayValid(rayValid),
  .rayBusy(rayBusy),
  .colValid(colValid),
  .mapValid(mapValid)
);

// File: bench/raycast_stim.txt
// word 0 ray count, then 24 map rows of 24 tiles (x left to right, y top to bottom)
// rays: col sxn syn dirX dirY dltX dltY posX posY sidX sidY mapX mapY | height side tile wallX
10
4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3
5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 5
0 0 0 0100 0000 0100 FFFF 0C80 0C80 0080 FFFF C C 0016 0 3 80
1 1 0 FF00 0000 0100 FFFF 0C80 0C80 0080 FFFF C C 0014 0 2 80
2 0 1 0000 FF00 FFFF 0100 0C80 0C80 FFFF 0080 C C 002B 1 6 80
3 0 0 0000 0100 FFFF 0100 0C80 0C80 FFFF 0080 C C 0016 1 5 80
4 0 0 0100 0000 0100 FFFF 1700 0C40 0000 FFFF 16 C FFFF 0 3 40
5 0 0 0100 0100 0100 0100 0C80 0C80 0080 0080 C C 0044 0 7 00
6 1 0 FF00 0080 0100 0200 0C80 0C40 0080 0180 C C 0014 0 2 00
7 0 1 0080 FF00 0200 0100 0C80 0C80 0100 0080 C C 0014 1 4 40
8 1 0 FF80 0100 0200 0100 0C80 0C80 0100 0080 C C 0016 1 5 40
9 0 0 0100 0000 0100 FFFF 0C80 0C80 0080 FFFF C C 0016 0 3 80
A 1 0 FF00 0000 0100 FFFF 0C80 0C80 0080 FFFF C C 0014 0 2 80
B 0 1 0000 FF00 FFFF 0100 0C80 0C80 FFFF 0080 C C 002B 1 6 80
C 0 0 0000 0100 FFFF 0100 0C80 0C80 FFFF 0080 C C 0016 1 5 80
D 0 0 0100 0000 0100 FFFF 1700 0C40 0000 FFFF 16 C FFFF 0 3 40
E 0 0 0100 0100 0100 0100 0C80 0C80 0080 0080 C C 0044 0 7 00
F 1 0 FF00 0080 0100 0200 0C80 0C40 0080 0180 C C 0014 0 2 00

// File: raycast.f
+incdir+.
src/rayPkg.sv
src/rayDispatch.sv
src/ddaCore.sv
src/mapArbiter.sv
src/columnCollect.sv
src/raycastTop.sv
bench/raycast_chk.sv
bench/raycastTb.sv

// File: raycast_config.svh
`ifndef RAYCAST_CONFIG_SVH
`define RAYCAST_CONFIG_SVH

// parallel DDA steppers behind the dispatcher
`define RC_NUM_CORES 4

// square tile map, side length in tiles
`define RC_MAP_DIM 24

// visible rows, numerator of the line height division
`define RC_SCREEN_HEIGHT 240

// quotient width of the line height divider, also its cycle count
`define RC_DIV_BITS 16

`endif

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module raycastTb -f raycast.f -o simRaycast

./obj_dir/simRaycast | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// File: src/columnCollect.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module columnCollect (
  input logic pixel_clk_in,
  input logic rst_in,
  input rayPkg::coreSelT done,
  input rayPkg::colResultT result [`RC_NUM_CORES],
  output rayPkg::coreSelT doneAck, // one-hot, same cycle as the capture
  output logic colValid,
  output rayPkg::colResultT colOut
);

  logic [$clog2(`RC_NUM_CORES)-1:0] rrPtr; // next core to favour
  logic [$clog2(`RC_NUM_CORES)-1:0] pickIdx;
  logic pickAny;

  // one finished core per pick, round robin from rrPtr
  // no pick while a pulse is out, so colValid never runs two cycles
  always_comb begin
    int cand;
    doneAck = '0;
    pickIdx = '0;
    pickAny = 1'b0;
    for (int i = 0; i < `RC_NUM_CORES; i++) begin
      cand = (int'(rrPtr) + i) % `RC_NUM_CORES;
      if (!pickAny && !colValid && done[cand]) begin
        pickAny = 1'b1;
        pickIdx = cand[$clog2(`RC_NUM_CORES)-1:0];
        doneAck[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (pickAny) begin
      colOut <= result[pickIdx]; // payload register
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      colValid <= 1'b0;
      rrPtr <= '0;
    end else begin
      colValid <= pickAny; // pulse, one cycle per collected core
      if (pickAny) begin
        if (pickIdx == ($clog2(`RC_NUM_CORES))'(`RC_NUM_CORES - 1)) begin
          rrPtr <= '0;
        end else begin
          rrPtr <= pickIdx + 1'b1;
        end
      end
    end
  end

endmodule

// File: src/ddaCore.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module ddaCore (
  input logic pixel_clk_in,
  input logic rst_in,
  input logic jobStart, // take jobData this edge
  input rayPkg::rayJobT jobData,
  output logic idle,
  output logic mapReq, // held until mapValid
  output rayPkg::mapAddrT mapAddr,
  input logic mapValid, // answer for our request
  input rayPkg::tileT mapData,
  output logic done, // held until doneAck
  output rayPkg::colResultT result,
  input logic doneAck
);

  // screen height in 8.8, so the quotient comes out in whole pixels
  localparam logic [`RC_DIV_BITS-1:0] lineDividend = `RC_SCREEN_HEIGHT * 256;

  rayPkg::ddaStateT state;
  rayPkg::rayJobT job; // copy of the ray being walked
  rayPkg::fixed88T sideX; // running side distances
  rayPkg::fixed88T sideY;
  rayPkg::mapCoordT cellX; // current cell
  rayPkg::mapCoordT cellY;
  logic wallSide; // side crossed by the last step
  rayPkg::tileT hitTile;
  rayPkg::fixed88T perpDist; // perpendicular wall distance

  logic takeX; // next step crosses an x side
  rayPkg::mapCoordT nextCellX;
  rayPkg::mapCoordT nextCellY;

  logic [`RC_DIV_BITS-1:0] divRem; // partial remainder
  logic [`RC_DIV_BITS-1:0] divQuo; // dividend shifting out, quotient shifting in
  logic [$clog2(`RC_DIV_BITS)-1:0] divCnt; // iterations left
  logic [`RC_DIV_BITS:0] divShift;
  logic [`RC_DIV_BITS+1:0] divTrial; // msb set means negative

  logic signed [32:0] fracProd; // distance times direction, 16.16
  rayPkg::fixed88T fracPos;
  logic [7:0] wallFrac;

  function automatic rayPkg::mapAddrT addrOf(rayPkg::mapCoordT x, rayPkg::mapCoordT y);
    return rayPkg::mapAddrT'(x) + rayPkg::mapAddrT'(y) * rayPkg::mapAddrT'(`RC_MAP_DIM);
  endfunction

  assign takeX = sideX < sideY; // tie goes to y
  assign nextCellX = job.stepXNeg ? cellX - 1'b1 : cellX + 1'b1;
  assign nextCellY = job.stepYNeg ? cellY - 1'b1 : cellY + 1'b1;

  // restoring divider, a zero divisor never goes negative so it saturates to all ones
  assign divShift = {divRem, divQuo[`RC_DIV_BITS-1]};
  assign divTrial = {1'b0, divShift} - (`RC_DIV_BITS+2)'(perpDist);

  // fraction runs along the axis opposite to the hit side
  always_comb begin
    if (wallSide) begin
      fracProd = $signed({1'b0, perpDist}) * $signed(job.rayDirX);
      fracPos = job.posX;
    end else begin
      fracProd = $signed({1'b0, perpDist}) * $signed(job.rayDirY);
      fracPos = job.posY;
    end
  end

  assign wallFrac = fracPos[7:0] + fracProd[15:8]; // only the fraction bits survive

  assign idle = state == rayPkg::IDLE;
  assign mapReq = state == rayPkg::WAIT_MAP;
  assign done = state == rayPkg::HOLD;

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state <= rayPkg::IDLE;
    end else begin
      case (state)
        rayPkg::IDLE: begin
          if (jobStart) begin
            job <= jobData;
            sideX <= jobData.sideDistX;
            sideY <= jobData.sideDistY;
            cellX <= jobData.mapX;
            cellY <= jobData.mapY;
            state <= rayPkg::STEP;
          end
        end
        rayPkg::STEP: begin
          if (takeX) begin
            sideX <= sideX + job.deltaDistX;
            cellX <= nextCellX;
            wallSide <= 1'b0;
            mapAddr <= addrOf(nextCellX, cellY);
          end else begin
            sideY <= sideY + job.deltaDistY;
            cellY <= nextCellY;
            wallSide <= 1'b1;
            mapAddr <= addrOf(cellX, nextCellY);
          end
          state <= rayPkg::WAIT_MAP;
        end
        rayPkg::WAIT_MAP: begin
          if (mapValid) begin
            if (mapData != '0) begin
              hitTile <= mapData;
              // side distance already moved past the wall, back off one delta
              perpDist <= wallSide ? sideY - job.deltaDistY : sideX - job.deltaDistX;
              divRem <= '0;
              divQuo <= lineDividend;
              divCnt <= ($clog2(`RC_DIV_BITS))'(`RC_DIV_BITS - 1);
              state <= rayPkg::DIVIDE;
            end else begin
              state <= rayPkg::STEP; // empty floor, keep walking
            end
          end
        end
        rayPkg::DIVIDE: begin
          if (divTrial[`RC_DIV_BITS+1]) begin
            divRem <= divShift[`RC_DIV_BITS-1:0]; // restore
            divQuo <= {divQuo[`RC_DIV_BITS-2:0], 1'b0};
          end else begin
            divRem <= divTrial[`RC_DIV_BITS-1:0];
            divQuo <= {divQuo[`RC_DIV_BITS-2:0], 1'b1};
          end
          divCnt <= divCnt - 1'b1;
          if (divCnt == '0) begin
            state <= rayPkg::FINISH;
          end
        end
        rayPkg::FINISH: begin
          result.column <= job.column;
          result.lineHeight <= divQuo;
          result.wallSide <= wallSide;
          result.tile <= hitTile;
          result.wallX <= wallFrac;
          state <= rayPkg::HOLD;
        end
        rayPkg::HOLD: begin
          if (doneAck) begin
            state <= rayPkg::IDLE; // result taken by the collector
          end
        end
        default: state <= rayPkg::IDLE;
      endcase
    end
  end

endmodule

// File: src/mapArbiter.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module mapArbiter (
  input logic pixel_clk_in,
  input logic rst_in,
  input logic mapWe, // load port, used between frames
  input rayPkg::mapAddrT mapWrAddr,
  input rayPkg::tileT mapWrData,
  input rayPkg::coreSelT mapReq,
  input rayPkg::mapAddrT mapAddr [`RC_NUM_CORES],
  output rayPkg::coreSelT mapValid, // one cycle after the grant
  output rayPkg::tileT mapData
);

  rayPkg::tileT mapRam [`RC_MAP_DIM*`RC_MAP_DIM];
  logic [$clog2(`RC_NUM_CORES)-1:0] rrPtr; // highest priority core
  logic [$clog2(`RC_NUM_CORES)-1:0] grantIdx;
  rayPkg::coreSelT eligible;
  rayPkg::coreSelT grant;
  logic grantAny;

  // a core still requests while its answer is on the bus
  assign eligible = mapReq & ~mapValid;

  // first eligible core at or after rrPtr
  always_comb begin
    int cand;
    grant = '0;
    grantIdx = '0;
    grantAny = 1'b0;
    for (int i = 0; i < `RC_NUM_CORES; i++) begin
      cand = (int'(rrPtr) + i) % `RC_NUM_CORES;
      if (!grantAny && eligible[cand]) begin
        grantAny = 1'b1;
        grantIdx = cand[$clog2(`RC_NUM_CORES)-1:0];
        grant[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (mapWe) begin
      mapRam[mapWrAddr] <= mapWrData;
    end
    mapData <= mapRam[mapAddr[grantIdx]]; // registered read for the granted core
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      mapValid <= '0;
      rrPtr <= '0;
    end else begin
      mapValid <= grant;
      if (grantAny) begin
        // move past the winner
        if (grantIdx == ($clog2(`RC_NUM_CORES))'(`RC_NUM_CORES - 1)) begin
          rrPtr <= '0;
        end else begin
          rrPtr <= grantIdx + 1'b1;
        end
      end
    end
  end

endmodule

// File: src/rayDispatch.sv
`timescale 1ns/1ps

module rayDispatch (
  input logic pixel_clk_in,
  input logic rst_in,
  input logic rayValid, // one cycle pulse with rayIn
  input rayPkg::rayJobT rayIn,
  input rayPkg::coreSelT coreIdle,
  output rayPkg::coreSelT jobStart, // one-hot start pulse
  output rayPkg::rayJobT jobData, // shared job bus
  output logic rayBusy
);

  rayPkg::rayJobT jobReg; // the single waiting job
  logic jobPending; // jobReg holds an unissued ray
  rayPkg::coreSelT idleMask; // core started last cycle
  rayPkg::coreSelT freeCores;

  // a core started last cycle is never picked twice, even if its idle level lags
  assign freeCores = coreIdle & ~idleMask;

  // lowest set bit wins
  assign jobStart = jobPending ?
                    (freeCores & rayPkg::coreSelT'(~freeCores + 1'b1)) :
                    '0;

  assign jobData = jobReg;

  // no room for another ray while one waits or every core is taken
  assign rayBusy = jobPending | ~|freeCores;

  always_ff @(posedge pixel_clk_in) begin
    if (rayValid) begin
      jobReg <= rayIn; // payload, no reset
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      jobPending <= 1'b0;
      idleMask <= '0;
    end else begin
      if (rayValid) begin
        jobPending <= 1'b1;
      end else if (|jobStart) begin
        jobPending <= 1'b0; // handed over this edge
      end
      idleMask <= jobStart; // hold the chosen core off for one cycle
    end
  end

endmodule

// File: src/rayPkg.sv
`include "raycast_config.svh"

package rayPkg;

  typedef logic [15:0] fixed88T; // 8.8 fixed point, signed where noted
  typedef logic [6:0] mapCoordT; // tile index on one axis
  typedef logic [$clog2(`RC_MAP_DIM*`RC_MAP_DIM)-1:0] mapAddrT; // x + y*dim
  typedef logic [10:0] columnT; // screen column of the ray
  typedef logic [3:0] tileT; // tile code, zero is empty floor
  typedef logic [`RC_NUM_CORES-1:0] coreSelT; // one bit per core

  // everything the stepper needs for one ray, prepared upstream
  typedef struct packed {
    columnT column;
    logic stepXNeg; // map x walks down
    logic stepYNeg; // map y walks down
    fixed88T rayDirX; // signed
    fixed88T rayDirY; // signed
    fixed88T deltaDistX;
    fixed88T deltaDistY;
    fixed88T posX;
    fixed88T posY;
    fixed88T sideDistX; // distance to first x side
    fixed88T sideDistY; // distance to first y side
    mapCoordT mapX; // starting cell
    mapCoordT mapY;
  } rayJobT;

  // one finished screen column
  typedef struct packed {
    columnT column;
    logic [`RC_DIV_BITS-1:0] lineHeight; // whole pixels
    logic wallSide; // 0 x side, 1 y side
    tileT tile; // code of the wall tile
    logic [7:0] wallX; // hit fraction along the wall
  } colResultT;

  typedef enum logic [2:0] {
    IDLE,
    STEP,
    WAIT_MAP,
    DIVIDE,
    FINISH,
    HOLD
  } ddaStateT;

endpackage

// File: src/raycastTop.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module raycastTop (
  input logic pixel_clk_in,
  input logic rst_in,
  input logic rayValid, // new ray pulse
  input rayPkg::rayJobT rayIn,
  output logic rayBusy, // hold rayValid off while high
  input logic mapWe,
  input rayPkg::mapAddrT mapWrAddr,
  input rayPkg::tileT mapWrData,
  output logic colValid, // finished column pulse
  output rayPkg::colResultT colOut
);

  rayPkg::coreSelT coreIdle;
  rayPkg::coreSelT jobStart;
  rayPkg::rayJobT jobData; // shared by all cores
  rayPkg::coreSelT mapReq;
  rayPkg::mapAddrT mapAddr [`RC_NUM_CORES];
  rayPkg::coreSelT mapValid;
  rayPkg::tileT mapData; // shared read bus
  rayPkg::coreSelT done;
  rayPkg::colResultT result [`RC_NUM_CORES];
  rayPkg::coreSelT doneAck;

  rayDispatch rayDispatch_i (
    .pixel_clk_in(pixel_clk_in),
    .rst_in(rst_in),
    .rayValid(rayValid),
    .rayIn(rayIn),
    .coreIdle(coreIdle),
    .jobStart(jobStart),
    .jobData(jobData),
    .rayBusy(rayBusy)
  );

  for (genvar c = 0; c < `RC_NUM_CORES; c++) begin : gCore
    ddaCore ddaCore_i (
      .pixel_clk_in(pixel_clk_in),
      .rst_in(rst_in),
      .jobStart(jobStart[c]),
      .jobData(jobData),
      .idle(coreIdle[c]),
      .mapReq(mapReq[c]),
      .mapAddr(mapAddr[c]),
      .mapValid(mapValid[c]),
      .mapData(mapData),
      .done(done[c]),
      .result(result[c]),
      .doneAck(doneAck[c])
    );
  end

  mapArbiter mapArbiter_i (
    .pixel_clk_in(pixel_clk_in),
    .rst_in(rst_in),
    .mapWe(mapWe),
    .mapWrAddr(mapWrAddr),
    .mapWrData(mapWrData),
    .mapReq(mapReq),
    .mapAddr(mapAddr),
    .mapValid(mapValid),
    .mapData(mapData)
  );

  columnCollect columnCollect_i (
    .pixel_clk_in(pixel_clk_in),
    .rst_in(rst_in),
    .done(done),
    .result(result),
    .doneAck(doneAck),
    .colValid(colValid),
    .colOut(colOut)
  );

endmodule
